// File: common/game_pkg.sv
package game_pkg;

    // board geometry
    localparam int board_width = 10;

    typedef logic [3:0] coord_t;  // h or v position on the board
    typedef logic [8:0] troop_t;  // troops held by one cell

    typedef enum logic [2:0] {
        npc  = 3'd0,
        red  = 3'd1,
        blue = 3'd2
    } player_e;

    typedef enum logic [1:0] {
        territory = 2'd0,
        mountain  = 2'd1,
        crown     = 2'd2,
        city      = 2'd3
    } piece_e;

    // upper bit set means a move mode
    typedef enum logic [1:0] {
        choose     = 2'b00,
        move_total = 2'b10,
        move_half  = 2'b11
    } cursor_mode_e;

    // key codes as sent by the keyboard decoder
    typedef enum logic [2:0] {
        w     = 3'd0,
        a     = 3'd1,
        s     = 3'd2,
        d     = 3'd3,
        space = 3'd4,
        z     = 3'd5,
        none  = 3'd6
    } op_e;

    // same order as w/a/s/d
    typedef enum logic [1:0] {
        up    = 2'd0,
        left  = 2'd1,
        down  = 2'd2,
        right = 2'd3
    } dir_e;

    // board layout after reset
    localparam coord_t red_crown_h  = 4'd2;
    localparam coord_t red_crown_v  = 4'd3;
    localparam coord_t blue_crown_h = 4'd8;
    localparam coord_t blue_crown_v = 4'd7;

    localparam troop_t red_crown_troop  = 9'h057;  // 87
    localparam troop_t blue_crown_troop = 9'h059;  // 89
    localparam troop_t city_troop       = 9'd40;

    // the two neutral cities
    localparam coord_t city0_h = 4'd5;
    localparam coord_t city0_v = 4'd1;
    localparam coord_t city1_h = 4'd1;
    localparam coord_t city1_v = 4'd8;

endpackage

// File: hdl/key_capture.sv
`timescale 1ns/10ps

module key_capture (
    input  logic           clk_100M,
    input  logic           arst_n,
    input  logic           keyboard_ready,
    input  logic [2:0]     keyboard_data,
    input  logic           op_clear,
    output game_pkg::op_e  op,
    output logic           op_valid,
    output logic           keyboard_read_fin
);
    import game_pkg::*;

    always_ff @(posedge clk_100M or negedge arst_n) begin
        if (!arst_n) begin
            op       <= none;
            op_valid <= 1'b0;
        end else if (keyboard_ready) begin
            // codes 6 and 7 carry no operation
            if (keyboard_data <= 3'd5) begin
                op       <= op_e'(keyboard_data);  // last key wins
                op_valid <= 1'b1;
            end
        end else if (op_clear) begin
            op       <= none;
            op_valid <= 1'b0;
        end
    end

    // ack every sampled key, valid or not
    always_ff @(posedge clk_100M or negedge arst_n) begin
        if (!arst_n) begin
            keyboard_read_fin <= 1'b0;
        end else begin
            keyboard_read_fin <= keyboard_ready;
        end
    end

    // decoder only sees an ack right after it offered a key
    a_ack_after_ready: assert property (
        @(posedge clk_100M) disable iff (!arst_n)
        keyboard_read_fin |-> $past(keyboard_ready)
    );

endmodule

// File: hdl/cursor_unit.sv
`timescale 1ns/10ps

module cursor_unit (
    input  logic              clk_100M,
    input  logic              arst_n,
    input  game_pkg::dir_e    dir,
    input  logic              step,
    input  logic              jump,
    input  game_pkg::player_e jump_to,
    output game_pkg::coord_t  cursor_h,
    output game_pkg::coord_t  cursor_v,
    output game_pkg::coord_t  nb_h,
    output game_pkg::coord_t  nb_v,
    output logic              nb_moved
);
    import game_pkg::*;

    // neighbour in direction dir, held at the board edge
    always_comb begin
        nb_h = cursor_h;
        nb_v = cursor_v;
        case (dir)
            up:    if (cursor_v != '0) nb_v = cursor_v - 1'b1;
            left:  if (cursor_h != '0) nb_h = cursor_h - 1'b1;
            down:  if (cursor_v < board_width - 1) nb_v = cursor_v + 1'b1;
            right: if (cursor_h < board_width - 1) nb_h = cursor_h + 1'b1;
            default: ;
        endcase
    end

    assign nb_moved = (nb_h != cursor_h) || (nb_v != cursor_v);  // low when clamped

    always_ff @(posedge clk_100M or negedge arst_n) begin
        if (!arst_n) begin
            cursor_h <= '0;
            cursor_v <= '0;
        end else if (jump) begin
            // turn change, go to the incoming player's crown
            if (jump_to == blue) begin
                cursor_h <= blue_crown_h;
                cursor_v <= blue_crown_v;
            end else begin
                cursor_h <= red_crown_h;
                cursor_v <= red_crown_v;
            end
        end else if (step) begin
            cursor_h <= nb_h;
            cursor_v <= nb_v;
        end
    end

    a_cursor_on_board: assert property (
        @(posedge clk_100M) disable iff (!arst_n)
        (cursor_h < board_width) && (cursor_v < board_width)
    );

endmodule

// File: board/board_store.sv
`timescale 1ns/10ps

module board_store (
    input  logic              clk_100M,
    input  logic              arst_n,
    input  game_pkg::coord_t  cursor_h,
    input  game_pkg::coord_t  cursor_v,
    input  game_pkg::coord_t  nb_h,
    input  game_pkg::coord_t  nb_v,
    input  logic              do_move,
    input  game_pkg::player_e mover,
    input  game_pkg::troop_t  src_troop_new,
    input  game_pkg::troop_t  tgt_troop_new,
    output game_pkg::player_e cur_owner,
    output game_pkg::piece_e  cur_piece,
    output game_pkg::troop_t  cur_troop,
    output game_pkg::player_e tgt_owner,
    output game_pkg::piece_e  tgt_piece,
    output game_pkg::troop_t  tgt_troop
);
    import game_pkg::*;

    // cell fields, indexed [h][v]
    player_e owner_mem [board_width][board_width];
    piece_e  piece_mem [board_width][board_width];
    troop_t  troop_mem [board_width][board_width];

    always_ff @(posedge clk_100M or negedge arst_n) begin
        if (!arst_n) begin
            for (int h = 0; h < board_width; h++) begin
                for (int v = 0; v < board_width; v++) begin
                    if (h == red_crown_h && v == red_crown_v) begin
                        owner_mem[h][v] <= red;
                        piece_mem[h][v] <= crown;
                        troop_mem[h][v] <= red_crown_troop;
                    end else if (h == blue_crown_h && v == blue_crown_v) begin
                        owner_mem[h][v] <= blue;
                        piece_mem[h][v] <= crown;
                        troop_mem[h][v] <= blue_crown_troop;
                    end else if (h == v) begin
                        // diagonal is all mountains
                        owner_mem[h][v] <= npc;
                        piece_mem[h][v] <= mountain;
                        troop_mem[h][v] <= '0;
                    end else if ((h == city0_h && v == city0_v) ||
                                 (h == city1_h && v == city1_v)) begin
                        owner_mem[h][v] <= npc;
                        piece_mem[h][v] <= city;
                        troop_mem[h][v] <= city_troop;
                    end else begin
                        owner_mem[h][v] <= npc;
                        piece_mem[h][v] <= territory;
                        troop_mem[h][v] <= '0;
                    end
                end
            end
        end else if (do_move) begin
            // source is the cursor cell, target its neighbour
            troop_mem[cursor_h][cursor_v] <= src_troop_new;
            troop_mem[nb_h][nb_v]         <= tgt_troop_new;
            owner_mem[nb_h][nb_v]         <= mover;  // piece kind stays
        end
    end

    // cursor read port
    assign cur_owner = owner_mem[cursor_h][cursor_v];
    assign cur_piece = piece_mem[cursor_h][cursor_v];
    assign cur_troop = troop_mem[cursor_h][cursor_v];

    // target read port
    assign tgt_owner = owner_mem[nb_h][nb_v];
    assign tgt_piece = piece_mem[nb_h][nb_v];
    assign tgt_troop = troop_mem[nb_h][nb_v];

endmodule

// File: board/move_calc.sv
`timescale 1ns/10ps

module move_calc (
    input  game_pkg::cursor_mode_e mode,
    input  game_pkg::troop_t       cur_troop,
    input  game_pkg::player_e      tgt_owner,
    input  game_pkg::piece_e       tgt_piece,
    output logic                   legal,
    output game_pkg::troop_t       src_troop_new,
    output game_pkg::troop_t       tgt_troop_new
);
    import game_pkg::*;

    troop_t half_troop;

    // only neutral open ground or neutral cities can be taken
    assign legal = (tgt_owner == npc) &&
                   ((tgt_piece == territory) || (tgt_piece == city));

    assign half_troop = cur_troop >> 1;  // rounds down

    always_comb begin
        case (mode)
            move_total: begin
                tgt_troop_new = cur_troop - 1'b1;
                src_troop_new = troop_t'(1);  // one stays behind
            end
            move_half: begin
                tgt_troop_new = half_troop;
                src_troop_new = cur_troop - half_troop;  // odd troop stays home
            end
            default: begin
                // no move in choose mode
                tgt_troop_new = '0;
                src_troop_new = cur_troop;
            end
        endcase
    end

endmodule

// File: hdl/game_ctrl.sv
`timescale 1ns/10ps

module game_ctrl (
    input  logic                   clk_100M,
    input  logic                   arst_n,
    input  logic                   keyboard_ready,
    input  game_pkg::op_e          op,
    input  logic                   op_valid,
    input  game_pkg::player_e      cur_owner,
    input  game_pkg::troop_t       cur_troop,
    input  logic                   nb_moved,
    input  logic                   legal,
    output logic                   op_clear,
    output game_pkg::dir_e         dir,
    output logic                   step,
    output logic                   jump,
    output game_pkg::player_e      jump_to,
    output logic                   do_move,
    output game_pkg::player_e      mover,
    output game_pkg::cursor_mode_e cursor_mode,
    output game_pkg::player_e      current_player
);
    import game_pkg::*;

    typedef enum logic {
        wait_op,
        exec
    } state_e;

    state_e  state;
    logic    run;
    logic    move_key;
    player_e next_player;

    // no game step while the decoder is handing over a key
    assign run = (state == exec) && !keyboard_ready;

    assign move_key    = op inside {w, a, s, d};
    assign dir         = dir_e'(op[1:0]);  // w/a/s/d map straight onto up/left/down/right
    assign next_player = (current_player == red) ? blue : red;

    assign op_clear = run;
    assign step     = run && (cursor_mode == choose) && move_key;
    assign do_move  = run && (cursor_mode != choose) && move_key && nb_moved && legal;
    assign jump     = do_move;  // every move ends the turn
    assign jump_to  = next_player;
    assign mover    = current_player;

    always_ff @(posedge clk_100M or negedge arst_n) begin
        if (!arst_n) begin
            state <= wait_op;
        end else begin
            case (state)
                wait_op: if (op_valid && !keyboard_ready) state <= exec;
                exec:    if (!keyboard_ready) state <= wait_op;
                default: state <= wait_op;
            endcase
        end
    end

    always_ff @(posedge clk_100M or negedge arst_n) begin
        if (!arst_n) begin
            cursor_mode    <= choose;
            current_player <= red;
        end else if (run) begin
            if (cursor_mode == choose) begin
                // pick up a stack of at least two own troops
                if (op == space && cur_owner == current_player && cur_troop >= 9'd2) begin
                    cursor_mode <= move_total;
                end
            end else if (op == z) begin
                cursor_mode <= (cursor_mode == move_total) ? move_half : move_total;
            end else if (op == space) begin
                cursor_mode <= choose;  // put it back down
            end else if (do_move) begin
                cursor_mode    <= choose;
                current_player <= next_player;
            end
        end
    end

    a_mode_encoding: assert property (
        @(posedge clk_100M) disable iff (!arst_n)
        cursor_mode != 2'b01
    );

endmodule

// File: hdl/game_player.sv
`timescale 1ns/10ps

module game_player (
    input  logic                   clk_100M,
    input  logic                   arst_n,
    input  logic                   keyboard_ready,
    input  logic [2:0]             keyboard_data,
    output logic                   keyboard_read_fin,
    output game_pkg::coord_t       cursor_h,
    output game_pkg::coord_t       cursor_v,
    output game_pkg::troop_t       cell_troop,
    output game_pkg::player_e      cell_owner,
    output game_pkg::piece_e       cell_piece,
    output game_pkg::player_e      current_player,
    output game_pkg::cursor_mode_e cursor_mode
);
    import game_pkg::*;

    op_e     op;
    logic    op_valid;
    logic    op_clear;
    dir_e    dir;
    logic    step;
    logic    jump;
    player_e jump_to;
    coord_t  nb_h;
    coord_t  nb_v;
    logic    nb_moved;
    player_e tgt_owner;
    piece_e  tgt_piece;
    logic    legal;
    troop_t  src_troop_new;
    troop_t  tgt_troop_new;
    logic    do_move;
    player_e mover;

    key_capture u_key_capture (
        .clk_100M          (clk_100M),
        .arst_n            (arst_n),
        .keyboard_ready    (keyboard_ready),
        .keyboard_data     (keyboard_data),
        .op_clear          (op_clear),
        .op                (op),
        .op_valid          (op_valid),
        .keyboard_read_fin (keyboard_read_fin)
    );

    cursor_unit u_cursor_unit (
        .clk_100M (clk_100M),
        .arst_n   (arst_n),
        .dir      (dir),
        .step     (step),
        .jump     (jump),
        .jump_to  (jump_to),
        .cursor_h (cursor_h),
        .cursor_v (cursor_v),
        .nb_h     (nb_h),
        .nb_v     (nb_v),
        .nb_moved (nb_moved)
    );

    // cursor cell feeds the status outputs directly
    board_store u_board_store (
        .clk_100M      (clk_100M),
        .arst_n        (arst_n),
        .cursor_h      (cursor_h),
        .cursor_v      (cursor_v),
        .nb_h          (nb_h),
        .nb_v          (nb_v),
        .do_move       (do_move),
        .mover         (mover),
        .src_troop_new (src_troop_new),
        .tgt_troop_new (tgt_troop_new),
        .cur_owner     (cell_owner),
        .cur_piece     (cell_piece),
        .cur_troop     (cell_troop),
        .tgt_owner     (tgt_owner),
        .tgt_piece     (tgt_piece),
        .tgt_troop     ()
    );

    move_calc u_move_calc (
        .mode          (cursor_mode),
        .cur_troop     (cell_troop),
        .tgt_owner     (tgt_owner),
        .tgt_piece     (tgt_piece),
        .legal         (legal),
        .src_troop_new (src_troop_new),
        .tgt_troop_new (tgt_troop_new)
    );

    game_ctrl u_game_ctrl (
        .clk_100M       (clk_100M),
        .arst_n         (arst_n),
        .keyboard_ready (keyboard_ready),
        .op             (op),
        .op_valid       (op_valid),
        .cur_owner      (cell_owner),
        .cur_troop      (cell_troop),
        .nb_moved       (nb_moved),
        .legal          (legal),
        .op_clear       (op_clear),
        .dir            (dir),
        .step           (step),
        .jump           (jump),
        .jump_to        (jump_to),
        .do_move        (do_move),
        .mover          (mover),
        .cursor_mode    (cursor_mode),
        .current_player (current_player)
    );

endmodule

// File: tb/tb_game_player.sv
`timescale 1ns/10ps

module tb_game_player;
    import game_pkg::*;

    localparam int table_len   = 41;
    localparam int random_keys = 200;
    localparam int cycle_limit = (table_len + random_keys) * 6 + 100;

    logic         clk_100M;
    logic         arst_n;
    logic         keyboard_ready;
    logic [2:0]   keyboard_data;
    logic         keyboard_read_fin;
    coord_t       cursor_h;
    coord_t       cursor_v;
    troop_t       cell_troop;
    player_e      cell_owner;
    piece_e       cell_piece;
    player_e      current_player;
    cursor_mode_e cursor_mode;

    // stimulus table, one key per entry with the expected status after it
    int t_key [table_len];
    int t_h [table_len];
    int t_v [table_len];
    int t_owner [table_len];
    int t_piece [table_len];
    int t_troop [table_len];
    int t_mode [table_len];
    int t_player [table_len];
    int n_entries = 0;

    // reference model of the board and the game state
    int m_owner [board_width][board_width];
    int m_piece [board_width][board_width];
    int m_troop [board_width][board_width];
    int m_h;
    int m_v;
    int m_mode;
    int m_player;

    int cycle_cnt = 0;

    game_player u_dut (
        .clk_100M          (clk_100M),
        .arst_n            (arst_n),
        .keyboard_ready    (keyboard_ready),
        .keyboard_data     (keyboard_data),
        .keyboard_read_fin (keyboard_read_fin),
        .cursor_h          (cursor_h),
        .cursor_v          (cursor_v),
        .cell_troop        (cell_troop),
        .cell_owner        (cell_owner),
        .cell_piece        (cell_piece),
        .current_player    (current_player),
        .cursor_mode       (cursor_mode)
    );

    always #5 clk_100M = ~clk_100M;

    always @(posedge clk_100M) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("simulation timed out after %0d cycles", cycle_cnt);
            $display("SOME TESTS FAILED");
            $fatal(1, "no progress within the cycle limit");
        end
    end

    task automatic check(input string field, input int actual, input int expected);
        if (actual != expected) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, field, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic compare_status(input int h, input int v, input int owner, input int piece,
                                  input int troop, input int mode, input int player);
        check("cursor_h", cursor_h, h);
        check("cursor_v", cursor_v, v);
        check("cell_owner", cell_owner, owner);
        check("cell_piece", cell_piece, piece);
        check("cell_troop", cell_troop, troop);
        check("cursor_mode", cursor_mode, mode);
        check("current_player", current_player, player);
    endtask

    task automatic add_entry(input int key, input int h, input int v, input int owner,
                             input int piece, input int troop, input int mode, input int player);
        t_key[n_entries]    = key;
        t_h[n_entries]      = h;
        t_v[n_entries]      = v;
        t_owner[n_entries]  = owner;
        t_piece[n_entries]  = piece;
        t_troop[n_entries]  = troop;
        t_mode[n_entries]   = mode;
        t_player[n_entries] = player;
        n_entries = n_entries + 1;
    endtask

    task automatic build_table;
        add_entry(w, 0, 0, npc, mountain, 0, choose, red);      // clamped at top
        add_entry(a, 0, 0, npc, mountain, 0, choose, red);      // clamped at left
        add_entry(space, 0, 0, npc, mountain, 0, choose, red);  // not red's cell
        add_entry(d, 1, 0, npc, territory, 0, choose, red);
        add_entry(d, 2, 0, npc, territory, 0, choose, red);
        add_entry(s, 2, 1, npc, territory, 0, choose, red);
        add_entry(s, 2, 2, npc, mountain, 0, choose, red);
        add_entry(s, 2, 3, red, crown, 87, choose, red);
        add_entry(space, 2, 3, red, crown, 87, move_total, red);
        add_entry(z, 2, 3, red, crown, 87, move_half, red);
        add_entry(z, 2, 3, red, crown, 87, move_total, red);
        add_entry(space, 2, 3, red, crown, 87, choose, red);
        add_entry(space, 2, 3, red, crown, 87, move_total, red);
        add_entry(d, 2, 3, red, crown, 87, move_total, red);    // onto mountain
        add_entry(w, 2, 3, red, crown, 87, move_total, red);    // onto mountain
        add_entry(s, 8, 7, blue, crown, 89, choose, blue);      // total move, turn to blue
        add_entry(space, 8, 7, blue, crown, 89, move_total, blue);
        add_entry(z, 8, 7, blue, crown, 89, move_half, blue);
        add_entry(a, 8, 7, blue, crown, 89, move_half, blue);   // onto mountain
        add_entry(w, 2, 3, red, crown, 1, choose, red);         // half move, back to red
        add_entry(s, 2, 4, red, territory, 86, choose, red);
        add_entry(6, 2, 4, red, territory, 86, choose, red);
        add_entry(7, 2, 4, red, territory, 86, choose, red);
        add_entry(d, 3, 4, npc, territory, 0, choose, red);
        add_entry(d, 4, 4, npc, mountain, 0, choose, red);
        add_entry(d, 5, 4, npc, territory, 0, choose, red);
        add_entry(d, 6, 4, npc, territory, 0, choose, red);
        add_entry(d, 7, 4, npc, territory, 0, choose, red);
        add_entry(d, 8, 4, npc, territory, 0, choose, red);
        add_entry(d, 9, 4, npc, territory, 0, choose, red);
        add_entry(d, 9, 4, npc, territory, 0, choose, red);     // right edge
        add_entry(s, 9, 5, npc, territory, 0, choose, red);
        add_entry(s, 9, 6, npc, territory, 0, choose, red);
        add_entry(s, 9, 7, npc, territory, 0, choose, red);
        add_entry(s, 9, 8, npc, territory, 0, choose, red);
        add_entry(s, 9, 9, npc, mountain, 0, choose, red);
        add_entry(s, 9, 9, npc, mountain, 0, choose, red);      // bottom edge
        add_entry(w, 9, 8, npc, territory, 0, choose, red);
        add_entry(w, 9, 7, npc, territory, 0, choose, red);
        add_entry(a, 8, 7, blue, crown, 45, choose, red);       // crown kept the odd half
        add_entry(w, 8, 6, blue, territory, 44, choose, red);   // taken by the half move
    endtask

    task automatic model_reset;
        for (int h = 0; h < board_width; h++) begin
            for (int v = 0; v < board_width; v++) begin
                m_owner[h][v] = npc;
                m_troop[h][v] = 0;
                m_piece[h][v] = (h == v) ? mountain : territory;
            end
        end
        m_piece[5][1] = city;
        m_troop[5][1] = 40;
        m_piece[1][8] = city;
        m_troop[1][8] = 40;
        m_owner[2][3] = red;
        m_piece[2][3] = crown;
        m_troop[2][3] = 87;
        m_owner[8][7] = blue;
        m_piece[8][7] = crown;
        m_troop[8][7] = 89;
        m_h = 0;
        m_v = 0;
        m_mode = choose;
        m_player = red;
    endtask

    task automatic model_key(input int code);
        int nh;
        int nv;
        int src;
        nh = m_h;
        nv = m_v;
        case (code)
            0: if (m_v > 0) nv = m_v - 1;
            1: if (m_h > 0) nh = m_h - 1;
            2: if (m_v < board_width - 1) nv = m_v + 1;
            3: if (m_h < board_width - 1) nh = m_h + 1;
            default: ;
        endcase
        src = m_troop[m_h][m_v];
        if (code > 5) begin
            // acknowledged only
        end else if (m_mode == choose) begin
            if (code <= 3) begin
                m_h = nh;
                m_v = nv;
            end else if (code == 4 && m_owner[m_h][m_v] == m_player && src >= 2) begin
                m_mode = move_total;
            end
        end else if (code == 5) begin
            m_mode = (m_mode == move_total) ? move_half : move_total;
        end else if (code == 4) begin
            m_mode = choose;
        end else if ((nh != m_h || nv != m_v) && m_owner[nh][nv] == npc &&
                     (m_piece[nh][nv] == territory || m_piece[nh][nv] == city)) begin
            if (m_mode == move_total) begin
                m_troop[nh][nv] = src - 1;
                m_troop[m_h][m_v] = 1;
            end else begin
                m_troop[nh][nv] = src / 2;
                m_troop[m_h][m_v] = src - src / 2;
            end
            m_owner[nh][nv] = m_player;
            m_player = (m_player == red) ? blue : red;
            m_h = (m_player == red) ? 2 : 8;  // crown of the incoming player
            m_v = (m_player == red) ? 3 : 7;
            m_mode = choose;
        end
    endtask

    // one key for one cycle, then ack check and settle time
    task automatic press_key(input int code);
        @(negedge clk_100M);
        keyboard_ready = 1'b1;
        keyboard_data  = code[2:0];
        @(negedge clk_100M);
        keyboard_ready = 1'b0;
        check("keyboard_read_fin", keyboard_read_fin, 1);
        @(negedge clk_100M);
        check("keyboard_read_fin", keyboard_read_fin, 0);  // single cycle pulse
        repeat (2) @(negedge clk_100M);
    endtask

    initial begin
        int seed_val;
        int code;
        clk_100M       = 1'b0;
        arst_n         = 1'b0;
        keyboard_ready = 1'b0;
        keyboard_data  = 3'd0;
        seed_val = $urandom(40);
        build_table();
        check("table length", n_entries, table_len);
        model_reset();
        repeat (5) @(negedge clk_100M);
        arst_n = 1'b1;
        @(negedge clk_100M);
        check("keyboard_read_fin", keyboard_read_fin, 0);
        compare_status(0, 0, npc, mountain, 0, choose, red);

        for (int i = 0; i < table_len; i++) begin
            press_key(t_key[i]);
            model_key(t_key[i]);  // keeps the model in step for the random part
            compare_status(t_h[i], t_v[i], t_owner[i], t_piece[i], t_troop[i],
                           t_mode[i], t_player[i]);
        end

        for (int i = 0; i < random_keys; i++) begin
            code = $urandom % 8;
            press_key(code);
            model_key(code);
            compare_status(m_h, m_v, m_owner[m_h][m_v], m_piece[m_h][m_v],
                           m_troop[m_h][m_v], m_mode, m_player);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: src.f
common/game_pkg.sv
hdl/key_capture.sv
hdl/cursor_unit.sv
board/board_store.sv
board/move_calc.sv
hdl/game_ctrl.sv
hdl/game_player.sv
tb/tb_game_player.sv
